//--- Bender.yml
package:
  name: clock_network

export_include_dirs:
  - logic

sources:
  # RTL in compile order, package first
  - include_dirs:
      - logic
    files:
      - logic/clknet_pkg.sv
      - logic/clock_gate.sv
      - logic/ripple_divider.sv
      - logic/lane_mixer.sv
      - logic/clock_network.sv

  # Bound assertions and the testbench top clock_network_tb
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/clock_network_assert.sv
      - testbench/clock_network_tb.sv

//--- clock_network.f
+incdir+logic
logic/clknet_pkg.sv
logic/clock_gate.sv
logic/ripple_divider.sv
logic/lane_mixer.sv
logic/clock_network.sv
testbench/clock_network_assert.sv
testbench/clock_network_tb.sv

//--- logic/clknet_cfg.svh
// Width and depth macros for the gated clock network, included by every file that sizes logic
`ifndef CLKNET_CFG_SVH
`define CLKNET_CFG_SVH

// ==============================
// Data path sizing
// ==============================

// Bits per byte lane
`define CLKNET_LANE_W 8

// Lanes in the output word, one per clock domain
`define CLKNET_LANES 4

// ==============================
// Clock and pipeline sizing
// ==============================

// Toggle stages in the ripple divider (div2, div4, div8)
`define CLKNET_DIV_STAGES 3

// Registers in each lane mixing pipeline
`define CLKNET_PIPE_DEPTH 8

// gclk cycles a vector must be held so the div8 lane settles
`define CLKNET_SETTLE_CYCLES 80

`endif

//--- logic/clknet_pkg.sv
// Shared data types for the gated clock network, referenced by scoped name from each module
`include "clknet_cfg.svh"

package clknet_pkg;

    // ==============================
    // Payload types
    // ==============================

    // One byte lane as carried through a mixing pipeline
    typedef logic [`CLKNET_LANE_W-1:0] lane_t;

    // Full data word
    // Lane 0 sits in the low byte
    typedef logic [`CLKNET_LANES*`CLKNET_LANE_W-1:0] word_t;

    // ==============================
    // Clock types
    // ==============================

    // Divided clocks from the ripple chain
    // Bit 0 is div2, bit 1 is div4, bit 2 is div8
    typedef logic [`CLKNET_DIV_STAGES-1:0] div_clks_t;

endpackage

//--- logic/clock_gate.sv
// Latch based integrated clock gate with scan override, used at the root and on each divided clock
module clock_gate (
    input  logic clk,
    input  logic en,
    input  logic scan_enable,
    output logic clk_gated
);

    // Enable as seen by the AND gate
    // Only updates during the low phase of clk
    logic en_latched;

    // ==============================
    // Enable latch
    // ==============================

    // Transparent while clk is low
    // Closed while clk is high so the gate cannot chop a pulse
    always_latch begin
        if (!clk) begin
            en_latched = en;
        end
    end

    // ==============================
    // Gated clock
    // ==============================

    // Scan forces the clock through regardless of the functional enable
    // A new enable shows up from the next rising edge of clk
    assign clk_gated = clk & (en_latched | scan_enable);

endmodule

//--- logic/clock_network.sv
// Top level of the gated clock network, wiring root gate, divider, per domain gates and byte lanes
`include "clknet_cfg.svh"

module clock_network (
    input  logic              gclk,
    input  logic              rst_n,
    input  logic              scan_enable,
    input  logic              main_clk_en,
    input  logic              enable,
    input  logic              en_div2,
    input  logic              en_div4,
    input  logic              en_div8,
    input  clknet_pkg::word_t data_in,
    output clknet_pkg::word_t data_out,
    output logic              core_clk
);

    // Divided clocks straight from the ripple chain
    clknet_pkg::div_clks_t div_clks;

    // Per domain gated clocks feeding the lanes
    logic lane_clk_div2;
    logic lane_clk_div4;
    logic lane_clk_div8;

    // Input to the core lane
    clknet_pkg::lane_t core_lane_in;

    // Lane results
    clknet_pkg::lane_t lane_core_out;
    clknet_pkg::lane_t lane_div2_out;
    clknet_pkg::lane_t lane_div4_out;
    clknet_pkg::lane_t lane_div8_out;

    // ==============================
    // Root clock gate
    // ==============================

    // Everything downstream runs off core_clk
    // core_clk is also brought out for monitoring
    clock_gate u_icg_main (
        .clk         (gclk),
        .en          (main_clk_en),
        .scan_enable (scan_enable),
        .clk_gated   (core_clk)
    );

    // ==============================
    // Divider chain
    // ==============================

    // div2, div4 and div8 from the gated root
    ripple_divider u_divider (
        .core_clk (core_clk),
        .rst_n    (rst_n),
        .enable   (enable),
        .div_clks (div_clks)
    );

    // ==============================
    // Per domain clock gates
    // ==============================

    // Each divided clock gets its own enable
    clock_gate u_icg_div2 (
        .clk         (div_clks[0]),
        .en          (en_div2),
        .scan_enable (scan_enable),
        .clk_gated   (lane_clk_div2)
    );

    clock_gate u_icg_div4 (
        .clk         (div_clks[1]),
        .en          (en_div4),
        .scan_enable (scan_enable),
        .clk_gated   (lane_clk_div4)
    );

    clock_gate u_icg_div8 (
        .clk         (div_clks[2]),
        .en          (en_div8),
        .scan_enable (scan_enable),
        .clk_gated   (lane_clk_div8)
    );

    // ==============================
    // Byte lanes
    // ==============================

    // Core lane mixes the lowest and highest input bytes
    assign core_lane_in = data_in[0 +: `CLKNET_LANE_W]
                        ^ data_in[3*`CLKNET_LANE_W +: `CLKNET_LANE_W];

    lane_mixer #(
        .step (8'hAA)
    ) u_lane_core (
        .lane_clk (core_clk),
        .rst_n    (rst_n),
        .lane_in  (core_lane_in),
        .lane_out (lane_core_out)
    );

    // div2 lane takes byte 0
    lane_mixer #(
        .step (8'h01)
    ) u_lane_div2 (
        .lane_clk (lane_clk_div2),
        .rst_n    (rst_n),
        .lane_in  (data_in[0 +: `CLKNET_LANE_W]),
        .lane_out (lane_div2_out)
    );

    // div4 lane takes byte 1
    lane_mixer #(
        .step (8'h02)
    ) u_lane_div4 (
        .lane_clk (lane_clk_div4),
        .rst_n    (rst_n),
        .lane_in  (data_in[`CLKNET_LANE_W +: `CLKNET_LANE_W]),
        .lane_out (lane_div4_out)
    );

    // div8 lane takes byte 2, slowest to settle
    lane_mixer #(
        .step (8'h04)
    ) u_lane_div8 (
        .lane_clk (lane_clk_div8),
        .rst_n    (rst_n),
        .lane_in  (data_in[2*`CLKNET_LANE_W +: `CLKNET_LANE_W]),
        .lane_out (lane_div8_out)
    );

    // ==============================
    // Output word
    // ==============================

    // Core lane in the top byte, div2 lane in the bottom byte
    assign data_out = {lane_core_out, lane_div8_out, lane_div4_out, lane_div2_out};

endmodule

//--- logic/lane_mixer.sv
// Eight stage byte mixing pipeline in one clock domain, instantiated once per lane of the top level
`include "clknet_cfg.svh"

module lane_mixer #(
    // Increment applied in stage 1
    parameter clknet_pkg::lane_t step = 8'h01
) (
    input  logic              lane_clk,
    input  logic              rst_n,
    input  clknet_pkg::lane_t lane_in,
    output clknet_pkg::lane_t lane_out
);

    // Pipeline registers
    // Each stage mixes the two stages before it
    clknet_pkg::lane_t stage [`CLKNET_PIPE_DEPTH];

    // ==============================
    // Mixing pipeline
    // ==============================

    // All stages advance together on lane_clk
    // A gated lane_clk freezes every stage in place
    always_ff @(posedge lane_clk or negedge rst_n) begin
        if (!rst_n) begin
            // Clear everything so the lane reads zero out of reset
            for (int i = 0; i < `CLKNET_PIPE_DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            // Capture the raw byte
            stage[0] <= lane_in;

            // Offset by the lane constant, modulo 256
            stage[1] <= stage[0] + step;

            // Difference bits between raw and offset value
            stage[2] <= stage[1] ^ stage[0];

            // Keep bits common to stages 1 and 2
            stage[3] <= stage[2] & stage[1];

            // Merge back the xor result
            stage[4] <= stage[3] | stage[2];

            // Sum wraps at eight bits
            stage[5] <= stage[4] + stage[3];

            // Subtract the or term again
            stage[6] <= stage[5] - stage[4];

            // Final fold
            stage[7] <= stage[6] ^ stage[5];
        end
    end

    // ==============================
    // Output
    // ==============================

    // Last stage drives the lane
    // Stable after CLKNET_PIPE_DEPTH edges of a steady input
    assign lane_out = stage[`CLKNET_PIPE_DEPTH-1];

endmodule

//--- logic/ripple_divider.sv
// Ripple chain of toggle flops producing div2, div4 and div8 clocks from the gated root clock
`include "clknet_cfg.svh"

module ripple_divider (
    input  logic                  core_clk,
    input  logic                  rst_n,
    input  logic                  enable,
    output clknet_pkg::div_clks_t div_clks
);

    // Clock seen by each stage
    // Stage 0 runs off core_clk, later stages off the previous output
    logic [`CLKNET_DIV_STAGES-1:0] stage_clk;

    // ==============================
    // Toggle stages
    // ==============================

    genvar n;
    for (n = 0; n < `CLKNET_DIV_STAGES; n++) begin : g_stage

        // Local toggle state for this stage
        logic toggle_q;

        // Pick the clock source for this stage
        if (n == 0) begin : g_root
            assign stage_clk[n] = core_clk;
        end else begin : g_chain
            assign stage_clk[n] = div_clks[n-1];
        end

        // Toggle on every rising edge of the source while running
        // Holds its level while enable is low
        always_ff @(posedge stage_clk[n] or negedge rst_n) begin
            if (!rst_n) begin
                toggle_q <= 1'b0;
            end else if (enable) begin
                toggle_q <= ~toggle_q;
            end
        end

        // Period doubles at each stage
        assign div_clks[n] = toggle_q;

    end

endmodule

//--- testbench/clock_network_assert.sv
// Concurrent checks on the clock network, bound into the top level from the testbench side
module clock_network_assert (
    input logic              gclk,
    input logic              rst_n,
    input logic              core_clk,
    input logic              main_clk_en,
    input logic              scan_enable,
    input logic              enable,
    input logic              div2_clk,
    input clknet_pkg::word_t data_out
);
    timeunit 1ns;
    timeprecision 100ps;

    // Failed assertions so far, read by the testbench at the end of the run
    int failures = 0;

    // ==============================
    // Root clock gate
    // ==============================

    // Late in the high phase the gated clock shows the enable latched in the low phase before it
    // Scan passes the clock straight through
    core_clk_follows_latched_en: assert property (
        @(negedge gclk) disable iff (!rst_n) core_clk == ($past(main_clk_en) | scan_enable))
        else begin
            failures++;
            $error("core_clk did not follow the enable latched before the gclk rising edge");
        end

    // ==============================
    // Reset and divider
    // ==============================

    // Asynchronous clear reaches every lane
    output_zero_in_reset: assert property (@(posedge gclk) !rst_n |-> data_out == '0)
        else begin
            failures++;
            $error("data_out not zero while rst_n is low, value %08h", data_out);
        end

    // div2 may only move after a core_clk edge that saw enable high
    div2_holds_when_stopped: assert property (
        @(posedge core_clk) disable iff (!rst_n) !$past(enable) |-> $stable(div2_clk))
        else begin
            failures++;
            $error("div2 clock toggled while the divider was disabled");
        end

endmodule

bind clock_network clock_network_assert u_assert (
    .gclk        (gclk),
    .rst_n       (rst_n),
    .core_clk    (core_clk),
    .main_clk_en (main_clk_en),
    .scan_enable (scan_enable),
    .enable      (enable),
    .div2_clk    (div_clks[0]),
    .data_out    (data_out)
);

//--- testbench/clock_network_stimulus.txt
// Columns: test number, control bits, data_in, expected data_out (all hex)
// Control bits from 5 down to 0: scan_enable main_clk_en enable en_div2 en_div4 en_div8
// A lane whose clock is stopped keeps the byte it held at the end of the previous test
01 1F 00000000 FE0C0603
02 1F 12345678 861C1E03
03 1F 3C7F80FF F6FC06FF
04 1D 9B2D4E67 5E3C061F
05 1F 9B2D4E67 5E3C3E1F
06 0F 00FF00FF 5E3C3E1F
07 2F 00FF00FF 56FC06FF
08 1F 00FF00FF 56FC06FF
09 17 11223344 FEFC06FF
0A 1F 11223344 FE0C0E03
0B 1A DEADBEEF 7E0CFE03
0C 1F DEADBEEF 7E3CFE3F

//--- testbench/clock_network_tb.sv
// Testbench for the gated clock network, replays the stimulus file and checks each settled word
`include "clknet_cfg.svh"

module clock_network_tb;
    timeunit 1ns;
    timeprecision 100ps;

    // ==============================
    // Run parameters
    // ==============================

    localparam int HALF_PERIOD = 50;
    localparam int MAX_VECTORS = 64;
    // Test number, control, data_in, expected
    localparam int FIELDS = 4;
    // Slowest lane gets one edge every 2**stages gclk cycles
    localparam int MIN_HOLD = `CLKNET_PIPE_DEPTH * (1 << `CLKNET_DIV_STAGES);
    localparam int HOLD_CYCLES = (`CLKNET_SETTLE_CYCLES > MIN_HOLD) ?
                                 `CLKNET_SETTLE_CYCLES : MIN_HOLD + 16;

    // DUT inputs and outputs
    logic              gclk;
    logic              rst_n;
    logic              scan_enable;
    logic              main_clk_en;
    logic              enable;
    logic              en_div2;
    logic              en_div4;
    logic              en_div8;
    clknet_pkg::word_t data_in;
    clknet_pkg::word_t data_out;
    logic              core_clk;

    // Flat copy of the stimulus file
    logic [31:0] vec_mem [FIELDS*MAX_VECTORS];

    int num_vectors = 0;
    int error_count = 0;
    int failed_tests = 0;
    int cycle_count = 0;
    // Zero until the vectors are counted
    int cycle_limit = 0;

    clock_network dut (
        .gclk        (gclk),
        .rst_n       (rst_n),
        .scan_enable (scan_enable),
        .main_clk_en (main_clk_en),
        .enable      (enable),
        .en_div2     (en_div2),
        .en_div4     (en_div4),
        .en_div8     (en_div8),
        .data_in     (data_in),
        .data_out    (data_out),
        .core_clk    (core_clk)
    );

    // 100 ns clock
    initial begin
        gclk = 1'b0;
        forever #HALF_PERIOD gclk = ~gclk;
    end

    // ==============================
    // Helpers
    // ==============================

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected, output bit ok);
        ok = (actual === expected);
        if (!ok) begin
            error_count++;
            $display("ERROR %s: actual %08h expected %08h", name, actual, expected);
        end
    endtask

    // Unused words carry their own address so a short file is easy to spot
    task automatic load_vectors();
        for (int a = 0; a < FIELDS * MAX_VECTORS; a++) begin
            vec_mem[a] = 32'hF000_0000 | a;
        end
        $readmemh("testbench/clock_network_stimulus.txt", vec_mem);
        // Tests are numbered from 1 without gaps
        while (num_vectors < MAX_VECTORS && vec_mem[FIELDS*num_vectors] == num_vectors + 1) begin
            num_vectors++;
        end
    endtask

    // Control bits 5..0 are scan, main gate, divider run, div2, div4, div8
    task automatic apply_vector(input int n);
        logic [5:0] ctrl;
        ctrl = vec_mem[FIELDS*n+1][5:0];
        @(posedge gclk);
        scan_enable <= ctrl[5];
        main_clk_en <= ctrl[4];
        enable      <= ctrl[3];
        en_div2     <= ctrl[2];
        en_div4     <= ctrl[1];
        en_div8     <= ctrl[0];
        data_in     <= vec_mem[FIELDS*n+2];
    endtask

    // ==============================
    // Main sequence
    // ==============================

    initial begin
        bit ok;
        bit clk_ok;
        logic clk_open;
        // All clocks stay off through reset
        rst_n       <= 1'b0;
        scan_enable <= 1'b0;
        main_clk_en <= 1'b0;
        enable      <= 1'b0;
        en_div2     <= 1'b0;
        en_div4     <= 1'b0;
        en_div8     <= 1'b0;
        data_in     <= '0;
        load_vectors();
        if (num_vectors == 0) begin
            error_count++;
            $display("The stimulus file holds no usable test vectors");
        end
        cycle_limit = (num_vectors + 2) * HOLD_CYCLES;

        repeat (2) @(posedge gclk);
        rst_n <= 1'b1;
        // Root gate is still closed, so core_clk stays low in the high phase
        #(HALF_PERIOD / 2);
        check_value("core_clk", core_clk, '0, clk_ok);
        @(negedge gclk);
        check_value("data_out", data_out, '0, ok);
        if (!ok || !clk_ok) begin
            failed_tests++;
        end
        $display("test 0 (reset) %s: data_out %08h", (ok && clk_ok) ? "ok" : "FAIL", data_out);

        for (int n = 0; n < num_vectors; n++) begin
            // Gate passes gclk when the main enable or scan is set
            clk_open = vec_mem[FIELDS*n+1][5] | vec_mem[FIELDS*n+1][4];
            apply_vector(n);
            repeat (HOLD_CYCLES) @(posedge gclk);
            // Quarter period into the high phase
            #(HALF_PERIOD / 2);
            check_value("core_clk", core_clk, clk_open, clk_ok);
            // Mid cycle, away from every lane clock edge
            @(negedge gclk);
            check_value("data_out", data_out, vec_mem[FIELDS*n+3], ok);
            if (!ok || !clk_ok) begin
                failed_tests++;
            end
            $display("test %0d %s: ctrl %02h data_in %08h data_out %08h", n + 1,
                     (ok && clk_ok) ? "ok" : "FAIL", vec_mem[FIELDS*n+1][5:0], data_in,
                     data_out);
        end

        $display("Done: %0d tests, %0d failed, %0d mismatches, %0d assertion failures",
                 num_vectors + 1, failed_tests, error_count, dut.u_assert.failures);
        if (error_count == 0 && dut.u_assert.failures == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // ==============================
    // Timeout
    // ==============================

    always @(posedge gclk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

endmodule
